// ==== include/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and pipeline word
`define DC_ADDR_WIDTH  32
`define DC_XLEN        64

// line geometry of four 64-bit beats
`define DC_LINE_BITS   256
`define DC_LINE_BEATS  4

// two ways of 64 sets
`define DC_SETS        64
`define DC_OFFSET_BITS 5
`define DC_INDEX_BITS  6
`define DC_TAG_BITS    21

// one mask bit per store byte
`define DC_MASK_BITS   8

`endif

// ==== design/dcachePkg.sv ====
`default_nettype none
`include "dcache_settings.svh"

package dcachePkg;

  typedef logic [`DC_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`DC_XLEN-1:0]        word_t;
  typedef logic [`DC_LINE_BITS-1:0]   line_t;
  typedef logic [`DC_TAG_BITS-1:0]    tag_t;
  typedef logic [`DC_INDEX_BITS-1:0]  index_t;
  typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
  typedef logic [`DC_MASK_BITS-1:0]   byteMask_t;

  // lookup, optional write-back, then refill and install
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    REFILL_REQ,
    REFILL,
    INSTALL
  } ctrlState_e;

endpackage

`default_nettype wire

// ==== design/requestLatch.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_settings.svh"

module requestLatch (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        reqValid_i,
  input  wire                        reqStore_i,
  input  wire dcachePkg::addr_t      reqAddr_i,
  input  wire dcachePkg::word_t      reqWrData_i,
  input  wire dcachePkg::byteMask_t  reqWrMask_i,
  input  wire                        accept_i,
  output dcachePkg::index_t          index_o,
  output dcachePkg::tag_t            tag_o,
  output dcachePkg::offset_t         offset_o,
  output logic                       isStore_o,
  output dcachePkg::word_t           storeWord_o,
  output dcachePkg::byteMask_t       storeMask_o
);
  import dcachePkg::*;

  logic [2:0] byteOff;

  // byte lane of the access inside the 64-bit word
  assign byteOff = reqAddr_i[2:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      isStore_o <= 1'b0;
    end else if (accept_i) begin
      isStore_o <= reqValid_i && reqStore_i;
    end
  end

  // store data arrives in the low bytes and moves to its lane
  always_ff @(posedge clk) begin
    if (accept_i) begin
      tag_o       <= reqAddr_i[`DC_ADDR_WIDTH-1 -: `DC_TAG_BITS];
      index_o     <= reqAddr_i[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
      offset_o    <= reqAddr_i[`DC_OFFSET_BITS-1:0];
      storeWord_o <= reqWrData_i << {byteOff, 3'b000};
      storeMask_o <= reqWrMask_i << byteOff;
    end
  end

endmodule

`default_nettype wire

// ==== design/tagStore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_settings.svh"

module tagStore (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire dcachePkg::index_t  rdIndex_i,
  input  wire dcachePkg::index_t  index_i,
  input  wire dcachePkg::tag_t    tag_i,
  input  wire                     lookup_i,
  input  wire                     install_i,
  input  wire                     markDirty_i,
  output logic [1:0]              wayHit_o,
  output logic                    hit_o,
  output logic                    victimWay_o,
  output logic                    victimDirty_o,
  output dcachePkg::tag_t         victimTag_o
);
  import dcachePkg::*;

  tag_t                tagMem [2][`DC_SETS];
  logic [`DC_SETS-1:0] validBits [2];
  logic [`DC_SETS-1:0] dirtyBits [2];
  tag_t                tagQ [2];
  logic [1:0]          validQ;
  logic [1:0]          dirtyQ;
  logic                victimSel;
  logic [1:0]          installWay;
  logic [1:0]          dirtyWay;
  index_t              rdAddr;

  // re-read the latched set during install so the second compare sees it
  assign rdAddr = install_i ? index_i : rdIndex_i;

  // victimSel has already toggled once the miss leaves COMPARE,
  // so outside a lookup the pending victim is its inverse
  assign victimWay_o = lookup_i ? victimSel : ~victimSel;

  assign installWay = {install_i && victimWay_o, install_i && !victimWay_o};
  assign dirtyWay   = {2{markDirty_i}} & wayHit_o;

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (installWay[w]) begin
        tagMem[w][index_i] <= tag_i;
      end
      tagQ[w] <= installWay[w] ? tag_i : tagMem[w][rdAddr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '{default: '0};
      dirtyBits <= '{default: '0};
      validQ    <= '0;
      dirtyQ    <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (installWay[w]) begin
          validBits[w][index_i] <= 1'b1;
          dirtyBits[w][index_i] <= 1'b0;
        end else if (dirtyWay[w]) begin
          dirtyBits[w][index_i] <= 1'b1;
        end
        // fresh line is valid and clean
        validQ[w] <= installWay[w] ? 1'b1 : validBits[w][rdAddr];
        dirtyQ[w] <= installWay[w] ? 1'b0 : dirtyBits[w][rdAddr];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimSel <= 1'b0;
    end else if (lookup_i && !hit_o) begin
      victimSel <= ~victimSel;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit_o[w] = validQ[w] && (tagQ[w] == tag_i);
    end
    hit_o         = |wayHit_o;
    victimDirty_o = dirtyQ[victimWay_o];
    victimTag_o   = tagQ[victimWay_o];
  end

endmodule

`default_nettype wire

// ==== design/dataStore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_settings.svh"

module dataStore (
  input  wire                        clk,
  input  wire dcachePkg::index_t     rdIndex_i,
  input  wire dcachePkg::index_t     index_i,
  input  wire dcachePkg::offset_t    offset_i,
  input  wire [1:0]                  wayHit_i,
  input  wire                        storeWr_i,
  input  wire dcachePkg::word_t      storeWord_i,
  input  wire dcachePkg::byteMask_t  storeMask_i,
  input  wire                        install_i,
  input  wire                        victimWay_i,
  input  wire dcachePkg::line_t      fillLine_i,
  output dcachePkg::word_t           loadWord_o,
  output dcachePkg::line_t           victimLine_o
);
  import dcachePkg::*;

  line_t      lineMem [2][`DC_SETS];
  line_t      rdLine [2];
  line_t      hitLine;
  logic [1:0] fillWay;
  logic [1:0] storeWay;
  logic [1:0] wordSel;
  index_t     rdAddr;

  // 64-bit word within the line
  assign wordSel  = offset_i[`DC_OFFSET_BITS-1:3];
  assign rdAddr   = install_i ? index_i : rdIndex_i;
  assign fillWay  = {install_i && victimWay_i, install_i && !victimWay_i};
  assign storeWay = {2{storeWr_i}} & wayHit_i;

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (fillWay[w]) begin
        lineMem[w][index_i] <= fillLine_i;
      end else if (storeWay[w]) begin
        for (int b = 0; b < `DC_MASK_BITS; b++) begin
          if (storeMask_i[b]) begin
            lineMem[w][index_i][wordSel*`DC_XLEN + b*8 +: 8] <= storeWord_i[b*8 +: 8];
          end
        end
      end
      // refilled line bypasses the array on the install edge
      rdLine[w] <= fillWay[w] ? fillLine_i : lineMem[w][rdAddr];
    end
  end

  always_comb begin
    hitLine      = wayHit_i[1] ? rdLine[1] : rdLine[0];
    loadWord_o   = hitLine[wordSel*`DC_XLEN +: `DC_XLEN];
    victimLine_o = rdLine[victimWay_i];
  end

endmodule

`default_nettype wire

// ==== design/missCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module missCtrl (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   reqValid_i,
  input  wire   isStore_i,
  input  wire   hit_i,
  input  wire   victimDirty_i,
  input  wire   memWrReady_i,
  input  wire   memRdLast_i,
  output logic  reqReady_o,
  output logic  accept_o,
  output logic  lookup_o,
  output logic  storeWr_o,
  output logic  install_o,
  output logic  wbStart_o,
  output logic  memWrValid_o,
  output logic  memRdReq_o,
  output logic  refilling_o,
  output logic  respValid_o
);
  import dcachePkg::*;

  ctrlState_e state;
  ctrlState_e nextState;
  logic       inCompare;

  assign inCompare = (state == COMPARE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept_o) begin
          nextState = COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          // a store hit always drops back to IDLE for a cycle
          nextState = accept_o ? COMPARE : IDLE;
        end else if (victimDirty_i) begin
          nextState = WRITEBACK;
        end else begin
          nextState = REFILL_REQ;
        end
      end
      WRITEBACK: begin
        if (memWrReady_i) begin
          nextState = REFILL_REQ;
        end
      end
      REFILL_REQ: nextState = REFILL;
      REFILL: begin
        if (memRdLast_i) begin
          nextState = INSTALL;
        end
      end
      INSTALL: nextState = COMPARE;
      default: nextState = IDLE;
    endcase
  end

  // load hits overlap with the next request
  assign reqReady_o   = (state == IDLE) || (inCompare && hit_i && !isStore_i);
  assign accept_o     = reqValid_i && reqReady_o;
  assign lookup_o     = inCompare;
  assign respValid_o  = inCompare && hit_i;
  assign storeWr_o    = inCompare && hit_i && isStore_i;
  assign wbStart_o    = inCompare && !hit_i && victimDirty_i;
  assign memWrValid_o = (state == WRITEBACK);
  assign memRdReq_o   = (state == REFILL_REQ);
  assign refilling_o  = (state == REFILL);
  assign install_o    = (state == INSTALL);

endmodule

`default_nettype wire

// ==== design/busPort.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_settings.svh"

module busPort (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     refilling_i,
  input  wire                     memRdValid_i,
  input  wire dcachePkg::word_t   memRdData_i,
  input  wire                     wbStart_i,
  input  wire dcachePkg::line_t   victimLine_i,
  input  wire dcachePkg::tag_t    victimTag_i,
  input  wire dcachePkg::index_t  index_i,
  input  wire dcachePkg::tag_t    tag_i,
  output dcachePkg::line_t        fillLine_o,
  output dcachePkg::addr_t        memRdAddr_o,
  output dcachePkg::addr_t        memWrAddr_o,
  output dcachePkg::line_t        memWrData_o
);
  import dcachePkg::*;

  logic [$clog2(`DC_LINE_BEATS)-1:0] beatCnt;
  logic                              beatTake;

  assign beatTake = refilling_i && memRdValid_i;

  // wraps to zero after the last beat of a line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest beat lands at the bottom of the line
  always_ff @(posedge clk) begin
    if (beatTake) begin
      fillLine_o[beatCnt*`DC_XLEN +: `DC_XLEN] <= memRdData_i;
    end
  end

  // victim snapshot taken as the miss leaves COMPARE
  always_ff @(posedge clk) begin
    if (wbStart_i) begin
      memWrAddr_o <= {victimTag_i, index_i, {`DC_OFFSET_BITS{1'b0}}};
      memWrData_o <= victimLine_i;
    end
  end

  assign memRdAddr_o = {tag_i, index_i, {`DC_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

// ==== design/dcacheTop.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_settings.svh"

module dcacheTop (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        reqValid_i,
  input  wire                        reqStore_i,
  input  wire dcachePkg::addr_t      reqAddr_i,
  input  wire dcachePkg::word_t      reqWrData_i,
  input  wire dcachePkg::byteMask_t  reqWrMask_i,
  output wire                        reqReady_o,
  output wire                        respValid_o,
  output wire dcachePkg::word_t      respData_o,
  output wire                        memRdReq_o,
  output wire dcachePkg::addr_t      memRdAddr_o,
  input  wire                        memRdValid_i,
  input  wire dcachePkg::word_t      memRdData_i,
  input  wire                        memRdLast_i,
  output wire                        memWrValid_o,
  output wire dcachePkg::addr_t      memWrAddr_o,
  output wire dcachePkg::line_t      memWrData_o,
  input  wire                        memWrReady_i
);

  wire dcachePkg::index_t    latIndex;
  wire dcachePkg::tag_t      latTag;
  wire dcachePkg::offset_t   latOffset;
  wire                       latStore;
  wire dcachePkg::word_t     storeWord;
  wire dcachePkg::byteMask_t storeMask;
  wire                       accept;
  wire [1:0]                 wayHit;
  wire                       hit;
  wire                       victimWay;
  wire                       victimDirty;
  wire dcachePkg::tag_t      victimTag;
  wire                       lookup;
  wire                       storeWr;
  wire                       install;
  wire                       wbStart;
  wire                       refilling;
  wire dcachePkg::line_t     victimLine;
  wire dcachePkg::line_t     fillLine;

  requestLatch u_requestLatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqStore_i  (reqStore_i),
    .reqAddr_i   (reqAddr_i),
    .reqWrData_i (reqWrData_i),
    .reqWrMask_i (reqWrMask_i),
    .accept_i    (accept),
    .index_o     (latIndex),
    .tag_o       (latTag),
    .offset_o    (latOffset),
    .isStore_o   (latStore),
    .storeWord_o (storeWord),
    .storeMask_o (storeMask)
  );

  // arrays see the incoming set index in the accept cycle
  tagStore u_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .rdIndex_i     (reqAddr_i[`DC_OFFSET_BITS +: `DC_INDEX_BITS]),
    .index_i       (latIndex),
    .tag_i         (latTag),
    .lookup_i      (lookup),
    .install_i     (install),
    .markDirty_i   (storeWr),
    .wayHit_o      (wayHit),
    .hit_o         (hit),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore u_dataStore (
    .clk          (clk),
    .rdIndex_i    (reqAddr_i[`DC_OFFSET_BITS +: `DC_INDEX_BITS]),
    .index_i      (latIndex),
    .offset_i     (latOffset),
    .wayHit_i     (wayHit),
    .storeWr_i    (storeWr),
    .storeWord_i  (storeWord),
    .storeMask_i  (storeMask),
    .install_i    (install),
    .victimWay_i  (victimWay),
    .fillLine_i   (fillLine),
    .loadWord_o   (respData_o),
    .victimLine_o (victimLine)
  );

  missCtrl u_missCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .isStore_i     (latStore),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .memWrReady_i  (memWrReady_i),
    .memRdLast_i   (memRdLast_i),
    .reqReady_o    (reqReady_o),
    .accept_o      (accept),
    .lookup_o      (lookup),
    .storeWr_o     (storeWr),
    .install_o     (install),
    .wbStart_o     (wbStart),
    .memWrValid_o  (memWrValid_o),
    .memRdReq_o    (memRdReq_o),
    .refilling_o   (refilling),
    .respValid_o   (respValid_o)
  );

  busPort u_busPort (
    .clk          (clk),
    .rst_n        (rst_n),
    .refilling_i  (refilling),
    .memRdValid_i (memRdValid_i),
    .memRdData_i  (memRdData_i),
    .wbStart_i    (wbStart),
    .victimLine_i (victimLine),
    .victimTag_i  (victimTag),
    .index_i      (latIndex),
    .tag_i        (latTag),
    .fillLine_o   (fillLine),
    .memRdAddr_o  (memRdAddr_o),
    .memWrAddr_o  (memWrAddr_o),
    .memWrData_o  (memWrData_o)
  );

endmodule

`default_nettype wire

// ==== verification/dcache_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_asserts (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    reqValid_i,
  input wire                    reqReady_i,
  input wire                    respValid_i,
  input wire                    memRdReq_i,
  input wire                    memWrValid_i,
  input wire                    memWrReady_i,
  input wire dcachePkg::addr_t  memWrAddr_i,
  input wire dcachePkg::line_t  memWrData_i
);

  int unsigned failCount = 0;

  // outputs held idle while in reset
  resetIdle: assert property (@(posedge clk)
    !rst_n |-> reqReady_i && !respValid_i && !memRdReq_i && !memWrValid_i)
  else begin
    failCount++;
    $error("outputs not idle during reset");
  end

  // requester only pulses valid while the cache is ready
  reqOnReady: assert property (@(posedge clk) disable iff (!rst_n)
    reqValid_i |-> reqReady_i)
  else begin
    failCount++;
    $error("request driven while reqReady_o was low");
  end

  // every accepted request gets its response
  respFollows: assert property (@(posedge clk) disable iff (!rst_n)
    reqValid_i && reqReady_i |-> ##[1:200] respValid_i)
  else begin
    failCount++;
    $error("accepted request never got a response");
  end

  // write-back address and line hold until memory takes them
  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_i && !memWrReady_i |=>
      memWrValid_i && $stable(memWrAddr_i) && $stable(memWrData_i))
  else begin
    failCount++;
    $error("write-back request dropped or changed before memWrReady_i");
  end

  // refill request only once memory has taken the write-back
  noReadDuringWb: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_i |-> !$past(memWrValid_i) || $past(memWrReady_i))
  else begin
    failCount++;
    $error("refill request issued before the write-back handshake");
  end

  rdReqPulse: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_i |=> !memRdReq_i)
  else begin
    failCount++;
    $error("memRdReq_o longer than one cycle");
  end

endmodule

bind dcacheTop dcache_asserts u_dcacheAsserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .reqValid_i   (reqValid_i),
  .reqReady_i   (reqReady_o),
  .respValid_i  (respValid_o),
  .memRdReq_i   (memRdReq_o),
  .memWrValid_i (memWrValid_o),
  .memWrReady_i (memWrReady_i),
  .memWrAddr_i  (memWrAddr_o),
  .memWrData_i  (memWrData_o)
);

`default_nettype wire

// ==== verification/dcacheTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcacheTb;
  import dcachePkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESP_LIMIT     = 100;
  localparam int SETS           = 64;

  logic      clk;
  logic      rst_n;
  logic      reqValid_i;
  logic      reqStore_i;
  addr_t     reqAddr_i;
  word_t     reqWrData_i;
  byteMask_t reqWrMask_i;
  logic      reqReady_o;
  logic      respValid_o;
  word_t     respData_o;
  logic      memRdReq_o;
  addr_t     memRdAddr_o;
  logic      memRdValid_i;
  word_t     memRdData_i;
  logic      memRdLast_i;
  logic      memWrValid_o;
  addr_t     memWrAddr_o;
  line_t     memWrData_o;
  logic      memWrReady_i;

  int    seed = 15884;
  int    errCount = 0;
  int    cycleCount = 0;
  int    wrStallCycles = 0;
  int    rdReqCount = 0;
  int    rdReqCycle = 0;
  addr_t lastRdAddr;
  int    wbCount = 0;
  int    wbCycle = 0;
  addr_t lastWbAddr;
  line_t lastWbLine;

  // memory contents written back so far by word address
  word_t memCopy [addr_t];

  // expected contents of every set and the victim bit shared by all sets
  tag_t  trkTag [SETS][2];
  bit    trkValid [SETS][2];
  bit    trkDirty [SETS][2];
  line_t trkLine [SETS][2];
  bit    victimToggle = 1'b0;

  dcacheTop u_dcacheTop (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqStore_i   (reqStore_i),
    .reqAddr_i    (reqAddr_i),
    .reqWrData_i  (reqWrData_i),
    .reqWrMask_i  (reqWrMask_i),
    .reqReady_o   (reqReady_o),
    .respValid_o  (respValid_o),
    .respData_o   (respData_o),
    .memRdReq_o   (memRdReq_o),
    .memRdAddr_o  (memRdAddr_o),
    .memRdValid_i (memRdValid_i),
    .memRdData_i  (memRdData_i),
    .memRdLast_i  (memRdLast_i),
    .memWrValid_o (memWrValid_o),
    .memWrAddr_o  (memWrAddr_o),
    .memWrData_o  (memWrData_o),
    .memWrReady_i (memWrReady_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // about ten accesses of a few dozen cycles each stay far below the limit
  initial begin : watchdog
    wait (cycleCount >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // untouched memory returns a value built from the whole address
  function automatic word_t modelWord(input addr_t a);
    if (memCopy.exists(a)) begin
      return memCopy[a];
    end
    return {a ^ 32'h5A3C_96E1, (a * 32'd40503) ^ 32'hC0DE_F00D};
  endfunction

  function automatic word_t mergeBytes(input word_t oldWord, input word_t newWord,
                                       input byteMask_t mask);
    word_t result;
    int    b;
    result = oldWord;
    for (b = 0; b < 8; b++) begin
      if (mask[b]) begin
        result[b*8 +: 8] = newWord[b*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic addr_t makeAddr(input tag_t tag, input index_t idx, input logic [1:0] word);
    return {tag, idx, word, 3'b000};
  endfunction

  task automatic checkValue(input string testName, input logic [255:0] expected,
                            input logic [255:0] actual);
    assert (actual === expected) else begin
      errCount++;
      $display("Error %s: expected %0h, actual %0h", testName, expected, actual);
    end
  endtask

  // snoop the memory port mid-cycle
  always @(negedge clk) begin
    int k;
    if (memRdReq_o) begin
      rdReqCount++;
      rdReqCycle = cycleCount;
      lastRdAddr = memRdAddr_o;
    end
    if (memWrValid_o && memWrReady_i) begin
      wbCount++;
      wbCycle = cycleCount;
      lastWbAddr = memWrAddr_o;
      lastWbLine = memWrData_o;
      for (k = 0; k < 4; k++) begin
        memCopy[memWrAddr_o + k*8] = memWrData_o[k*64 +: 64];
      end
    end
  end

  // four beats lowest first from the cycle after the request
  initial begin : readModel
    addr_t beatBase;
    int    b;
    memRdValid_i = 1'b0;
    memRdLast_i  = 1'b0;
    memRdData_i  = '0;
    forever begin
      @(negedge clk);
      if (memRdReq_o) begin
        beatBase = memRdAddr_o;
        for (b = 0; b < 4; b++) begin
          @(posedge clk);
          #2;
          memRdValid_i = 1'b1;
          memRdData_i  = modelWord(beatBase + b*8);
          memRdLast_i  = (b == 3);
        end
        @(posedge clk);
        #2;
        memRdValid_i = 1'b0;
        memRdLast_i  = 1'b0;
      end
    end
  end

  // holds memWrReady_i low for wrStallCycles of each write-back
  initial begin : writeReadyDriver
    int stallCnt;
    stallCnt = 0;
    memWrReady_i = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (memWrValid_o && stallCnt >= wrStallCycles) begin
        memWrReady_i = 1'b1;
      end else begin
        memWrReady_i = 1'b0;
        stallCnt = memWrValid_o ? stallCnt + 1 : 0;
      end
    end
  end

  // predicts hit, victim, write-back and returned word
  task automatic modelAccess(input addr_t addr, input bit store, input word_t data,
                             input byteMask_t mask, output bit wasHit, output bit expWb,
                             output addr_t expWbAddr, output line_t expWbLine,
                             output word_t expData);
    tag_t   tag;
    index_t idx;
    int     wordIdx;
    int     way;
    int     w;
    line_t  fresh;
    tag = addr[31:11];
    idx = addr[10:5];
    wordIdx = addr[4:3];
    way = -1;
    for (w = 0; w < 2; w++) begin
      if (trkValid[idx][w] && trkTag[idx][w] == tag) begin
        way = w;
      end
    end
    wasHit = (way >= 0);
    expWb = 1'b0;
    expWbAddr = '0;
    expWbLine = '0;
    if (!wasHit) begin
      // victim bit flips on every miss
      way = victimToggle;
      victimToggle = !victimToggle;
      expWb = trkValid[idx][way] && trkDirty[idx][way];
      expWbAddr = {trkTag[idx][way], idx, 5'b00000};
      expWbLine = trkLine[idx][way];
      for (w = 0; w < 4; w++) begin
        fresh[w*64 +: 64] = modelWord({tag, idx, 5'b00000} + w*8);
      end
      trkLine[idx][way] = fresh;
      trkTag[idx][way] = tag;
      trkValid[idx][way] = 1'b1;
      trkDirty[idx][way] = 1'b0;
    end
    if (store) begin
      trkLine[idx][way][wordIdx*64 +: 64] =
        mergeBytes(trkLine[idx][way][wordIdx*64 +: 64], data, mask);
      trkDirty[idx][way] = 1'b1;
    end
    expData = trkLine[idx][way][wordIdx*64 +: 64];
  endtask

  // entered and left 2 ns after a rising edge
  task automatic doRequest(input addr_t addr, input bit store, input word_t data,
                           input byteMask_t mask, output word_t rdata, output int latency);
    while (!reqReady_o) begin
      @(posedge clk);
      #2;
    end
    reqValid_i  = 1'b1;
    reqStore_i  = store;
    reqAddr_i   = addr;
    reqWrData_i = data;
    reqWrMask_i = mask;
    @(posedge clk);
    #2;
    reqValid_i = 1'b0;
    reqStore_i = 1'b0;
    latency = 1;
    while (!respValid_o && latency < RESP_LIMIT) begin
      @(posedge clk);
      #2;
      latency++;
    end
    assert (respValid_o) else begin
      errCount++;
      $display("No response within %0d cycles for the request to %h", RESP_LIMIT, addr);
    end
    rdata = respData_o;
  endtask

  task automatic runAccess(input string testName, input addr_t addr, input bit store,
                           input word_t data, input byteMask_t mask);
    bit    wasHit;
    bit    expWb;
    addr_t expWbAddr;
    line_t expWbLine;
    word_t expData;
    word_t rdata;
    int    latency;
    int    rdBefore;
    int    wbBefore;
    modelAccess(addr, store, data, mask, wasHit, expWb, expWbAddr, expWbLine, expData);
    rdBefore = rdReqCount;
    wbBefore = wbCount;
    doRequest(addr, store, data, mask, rdata, latency);
    if (!store) begin
      checkValue({testName, " data"}, expData, rdata);
    end
    checkValue({testName, " read requests"}, wasHit ? 0 : 1, rdReqCount - rdBefore);
    checkValue({testName, " write-backs"}, expWb, wbCount - wbBefore);
    if (wasHit) begin
      checkValue({testName, " latency"}, 1, latency);
    end else begin
      checkValue({testName, " read address"}, {addr[31:5], 5'b00000}, lastRdAddr);
    end
    if (expWb) begin
      checkValue({testName, " write-back address"}, expWbAddr, lastWbAddr);
      checkValue({testName, " write-back line"}, expWbLine, lastWbLine);
      checkValue({testName, " write-back before refill"}, 1, wbCycle < rdReqCycle);
    end
  endtask

  initial begin : stimulus
    word_t     randData;
    byteMask_t randMask;
    int        asrtFails;
    rst_n       = 1'b0;
    reqValid_i  = 1'b0;
    reqStore_i  = 1'b0;
    reqAddr_i   = '0;
    reqWrData_i = '0;
    reqWrMask_i = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    checkValue("afterReset", 4'b1000, {reqReady_o, respValid_o, memRdReq_o, memWrValid_o});

    runAccess("coldLoad", makeAddr(21'h00012, 6'd5, 2'd1), 1'b0, '0, '0);
    runAccess("repeatLoad", makeAddr(21'h00012, 6'd5, 2'd2), 1'b0, '0, '0);
    runAccess("backToBackLoad", makeAddr(21'h00012, 6'd5, 2'd3), 1'b0, '0, '0);

    randData = {$random(seed), $random(seed)};
    randMask = $random(seed);
    runAccess("storeHit", makeAddr(21'h00012, 6'd5, 2'd1), 1'b1, randData, randMask);
    runAccess("loadAfterStore", makeAddr(21'h00012, 6'd5, 2'd1), 1'b0, '0, '0);

    // second way of set 5 and then a third tag that evicts the dirty line
    runAccess("secondTag", makeAddr(21'h00ABC, 6'd5, 2'd0), 1'b0, '0, '0);
    wrStallCycles = 6;
    runAccess("dirtyEviction", makeAddr(21'h1F0F0, 6'd5, 2'd2), 1'b0, '0, '0);
    wrStallCycles = 0;
    runAccess("reloadEvicted", makeAddr(21'h00012, 6'd5, 2'd1), 1'b0, '0, '0);

    randData = {$random(seed), $random(seed)};
    randMask = $random(seed);
    runAccess("storeMiss", makeAddr(21'h00012, 6'd9, 2'd2), 1'b1, randData, randMask);
    runAccess("loadAfterStoreMiss", makeAddr(21'h00012, 6'd9, 2'd2), 1'b0, '0, '0);

    repeat (4) @(posedge clk);
    asrtFails = u_dcacheTop.u_dcacheAsserts.failCount;
    $display("Check errors: %0d, assertion failures: %0d", errCount, asrtFails);
    if (errCount == 0 && asrtFails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/dcachePkg.sv
design/requestLatch.sv
design/tagStore.sv
design/dataStore.sv
design/missCtrl.sv
design/busPort.sv
design/dcacheTop.sv
verification/dcache_asserts.sv
verification/dcacheTb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - include
    files:
      - design/dcachePkg.sv
      - design/requestLatch.sv
      - design/tagStore.sv
      - design/dataStore.sv
      - design/missCtrl.sv
      - design/busPort.sv
      - design/dcacheTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/dcache_asserts.sv
      - verification/dcacheTb.sv
